// ==== bnn/bnn_classifier.sv ====
`timescale 1ns/100ps

module bnn_classifier import bnn_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                bnn_start,
  input  logic [IMG_BITS-1:0] img_in,
  output logic [CLASS_W-1:0]  result_out,
  output logic                result_ready
);

  logic                busy;
  logic [CLASS_W-1:0]  cls_idx;      // Class scored this cycle
  logic [CLASS_W-1:0]  best_idx;
  logic [SCORE_W-1:0]  best_score;
  logic [SCORE_W-1:0]  score;
  logic [IMG_BITS-1:0] img_reg;      // Snapshot taken at start
  logic [IMG_BITS-1:0] match_vec;
  logic                better;
  logic                last_cls;

  // ==========================================================================
  // XNOR popcount for the current class
  // ==========================================================================
  assign match_vec = ~(img_reg ^ bnn_weight_row(cls_idx));

  always_comb begin
    score = '0;
    for (int i = 0; i < IMG_BITS; i++) score = score + SCORE_W'(match_vec[i]);
  end

  assign better   = (score > best_score);   // Strict, so ties keep lower index
  assign last_cls = (cls_idx == CLASS_W'(CLASS_COUNT - 1));

  always_ff @(posedge clk) begin
    if (bnn_start && !busy) img_reg <= img_in;
  end

  // ==========================================================================
  // Sweep and argmax
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      cls_idx      <= '0;
      best_idx     <= '0;
      best_score   <= '0;
      result_out   <= '0;
      result_ready <= 1'b0;
    end else begin
      result_ready <= 1'b0;                 // One-cycle pulse
      if (!busy) begin
        if (bnn_start) begin
          busy       <= 1'b1;
          cls_idx    <= '0;
          best_idx   <= '0;
          best_score <= '0;
        end
      end else begin
        if (better) begin
          best_score <= score;
          best_idx   <= cls_idx;
        end
        if (last_cls) begin
          busy         <= 1'b0;
          result_ready <= 1'b1;
          result_out   <= better ? cls_idx : best_idx;  // Include final class
        end else begin
          cls_idx <= cls_idx + 1'b1;
        end
      end
    end
  end

endmodule

// ==== common/bnn_pkg.sv ====
package bnn_pkg;

  // ==========================================================================
  // Sizes
  // ==========================================================================
  localparam int IMG_BYTES   = 16;   // Image bytes per load frame
  localparam int IMG_BITS    = 128;  // Binary pixels
  localparam int CLASS_COUNT = 10;   // Digits 0..9
  localparam int SCORE_W     = 8;    // Holds 0..128
  localparam int CLASS_W     = 4;    // Class index width

  // Base pattern for every weight row
  localparam logic [31:0] W_SEED = 32'h9E3779B9;

  // Host command bytes
  typedef enum logic [7:0] {
    OP_LOAD  = 8'hA1,  // Image follows
    OP_RUN   = 8'hB2,  // Classify current buffer
    OP_CLEAR = 8'hC3   // Zero the buffer
  } opcode_t;

  typedef enum logic [2:0] {
    ST_IDLE,  // Waiting for chip select
    ST_CMD,   // Expecting opcode byte
    ST_LOAD,  // Streaming image bytes
    ST_RUN,   // Classifier busy after OP_RUN
    ST_WAIT,  // Classifier busy after a full load
    ST_SKIP   // Rest of frame ignored
  } ctrl_state_t;

  // Weight row of class k: seed rotated left by 3k, tiled four times
  function automatic logic [IMG_BITS-1:0] bnn_weight_row(input logic [CLASS_W-1:0] k);
    int          sh;
    logic [31:0] rot;
    sh  = (3 * int'(k)) % 32;
    rot = (W_SEED << sh) | (W_SEED >> (32 - sh));  // sh = 0 leaves seed as is
    return {4{rot}};                                // Row bit 0 = word bit 0
  endfunction

endpackage

// ==== list.f ====
common/bnn_pkg.sv
src/spi_peripheral.sv
src/controller_fsm.sv
src/pixel_counter.sv
src/image_buffer.sv
bnn/bnn_classifier.sv
src/result_display.sv
src/system_controller.sv
sim/system_controller_props.sv
sim/tb_checker.sv
sim/tb_system_controller.sv

// ==== sim/system_controller_props.sv ====
`timescale 1ns/100ps

module system_controller_props import bnn_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        send_image,
  input logic        status_ready,
  input logic        result_ready,
  input logic        bnn_start,
  input logic        clear_buffer,
  input logic        buffer_write_enable,
  input ctrl_state_t state
);

  int assert_fails = 0;  // Failed assertions so far

  a_busy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(send_image && status_ready))
    else begin
      assert_fails++;
      $error("send_image and status_ready high together");
    end

  a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    result_ready |=> !result_ready)
    else begin
      assert_fails++;
      $error("result_ready held longer than one cycle");
    end

  a_start_state: assert property (@(posedge clk) disable iff (!rst_n)
    bnn_start |-> (state == ST_CMD || state == ST_LOAD))
    else begin
      assert_fails++;
      $error("bnn_start outside ST_CMD and ST_LOAD");
    end

  a_wr_clr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(clear_buffer && buffer_write_enable))
    else begin
      assert_fails++;
      $error("clear_buffer and buffer_write_enable high together");
    end

endmodule

bind controller_fsm system_controller_props u_props (
  .clk, .rst_n, .send_image, .status_ready, .result_ready,
  .bnn_start, .clear_buffer, .buffer_write_enable, .state
);

// ==== sim/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [6:0] seg,
  input  logic       result_ready,
  input  logic       send_image,
  input  logic       status_ready,
  input  logic       in_load,       // Stimulus is inside the image bytes
  input  logic       exp_push,      // Expected winner arrives on exp_class
  input  logic [3:0] exp_class,
  input  logic       test_end,
  input  int         test_kind,
  output int         pending,       // Results still owed by the DUT
  output int         err_count,
  output int         tests_pass,
  output int         tests_fail
);

  logic [3:0] exp_q[$];             // Winners in frame order
  logic [3:0] shown_cls = 4'd0;     // Digit seg should show now
  logic       reset_seen = 1'b0;
  logic       seg_bad = 1'b0;       // Report a bad seg once per episode
  logic       busy_win = 1'b0;      // Load or classification under way
  int         test_no = 0;
  int         err_base = 0;

  initial begin
    pending    = 0;
    err_count  = 0;
    tests_pass = 0;
    tests_fail = 0;
  end

  // Active low, bit 6 = g down to bit 0 = a
  function automatic logic [6:0] seg_of(input logic [3:0] d);
    case (d)
      4'd0:    return 7'b1000000;
      4'd1:    return 7'b1111001;
      4'd2:    return 7'b0100100;
      4'd3:    return 7'b0110000;
      4'd4:    return 7'b0011001;
      4'd5:    return 7'b0010010;
      4'd6:    return 7'b0000010;
      4'd7:    return 7'b1111000;
      4'd8:    return 7'b0000000;
      4'd9:    return 7'b0010000;
      default: return 7'b1111111;
    endcase
  endfunction

  function automatic string kind_name(input int k);
    case (k)
      0:       return "reset state";
      1:       return "full load";
      2:       return "clear then run";
      3:       return "aborted load then run";
      default: return "unknown opcode";
    endcase
  endfunction

  // ==========================================================================
  // Sampled mid-cycle, away from both edges of activity
  // ==========================================================================
  always @(negedge clk) begin
    if (rst_n) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (status_ready !== 1'b1 || send_image !== 1'b0 || result_ready !== 1'b0) begin
          err_count++;
          $display("mismatch at %0t: after reset status_ready=%b send_image=%b result_ready=%b",
                   $time, status_ready, send_image, result_ready);
        end
      end
      if (exp_push) exp_q.push_back(exp_class);
      if (seg !== seg_of(shown_cls)) begin
        if (!seg_bad) begin
          err_count++;
          $display("mismatch at %0t: seg=%b expected %b for class %0d",
                   $time, seg, seg_of(shown_cls), shown_cls);
        end
        seg_bad = 1'b1;
      end else begin
        seg_bad = 1'b0;
      end
      if (in_load) busy_win = 1'b1;
      if (in_load && send_image !== 1'b1) begin
        err_count++;
        $display("mismatch at %0t: send_image low while image bytes stream", $time);
      end
      if (busy_win && status_ready !== 1'b0) begin
        err_count++;
        $display("mismatch at %0t: status_ready high during load or classification", $time);
      end
      if (result_ready) begin
        busy_win = 1'b0;                   // Classification over
        if (exp_q.size() == 0) begin
          err_count++;
          $display("unexpected result_ready pulse at %0t with no result pending", $time);
        end else begin
          shown_cls = exp_q.pop_front();   // Latched by the display next edge
        end
      end
      if (test_end) begin
        test_no++;
        if (exp_q.size() != 0) begin
          err_count++;
          $display("test %0d ended at %0t while %0d result_ready pulse(s) never came",
                   test_no, $time, exp_q.size());
          exp_q.delete();
        end
        if (err_count == err_base) begin
          tests_pass++;
          $display("test %0d %s: ok", test_no, kind_name(test_kind));
        end else begin
          tests_fail++;
          $display("test %0d %s: failed with %0d error(s)", test_no,
                   kind_name(test_kind), err_count - err_base);
        end
        err_base = err_count;
      end
      pending = exp_q.size();
    end
  end

endmodule

// ==== sim/tb_system_controller.sv ====
`timescale 1ns/100ps

module tb_system_controller import bnn_pkg::*; ();

  localparam int  N_LOADS     = 6;
  localparam int  N_ABORTS    = 3;
  localparam int  N_UNKNOWN   = 3;
  localparam int  N_FRAMES    = N_LOADS + 2 + 2 * N_ABORTS + N_UNKNOWN;
  localparam real WATCHDOG_NS = N_FRAMES * 17 * 8 * 8 * 100.0 + 20000.0;
  localparam int  IDLE_LIMIT  = 400;  // Cycles allowed for a frame to settle

  logic         clk, rst_n, sclk, copi, spi_cs_n;
  logic [6:0]   seg;
  logic         result_ready, send_image, status_ready;
  logic         in_load, exp_push, test_end;
  logic [3:0]   exp_class;
  int           test_kind;
  int           pending, err_count, tests_pass, tests_fail;
  int           stall_errs, total_errs;
  logic [31:0]  rng;
  logic [127:0] model_img;               // Buffer contents as the host sees them
  logic [7:0]   frame_data [IMG_BYTES];  // Payload of the next frame
  logic [7:0]   op;
  int           n;

  always #50 clk = ~clk;

  system_controller DUT (
    .clk, .rst_n, .sclk, .copi, .spi_cs_n,
    .seg, .result_ready, .send_image, .status_ready
  );

  tb_checker chk (
    .clk, .rst_n, .seg, .result_ready, .send_image, .status_ready,
    .in_load, .exp_push, .exp_class, .test_end, .test_kind,
    .pending, .err_count, .tests_pass, .tests_fail
  );

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [127:0] class_weights(input int k);
    logic [31:0] w;
    w = W_SEED;
    repeat (3 * k) w = {w[30:0], w[31]};  // Rotate left a bit at a time
    return {4{w}};
  endfunction

  function automatic logic [3:0] model_winner(input logic [127:0] img);
    logic [127:0] agree;
    int           score, best_score;
    logic [3:0]   best;
    best       = 4'd0;
    best_score = -1;
    for (int k = 0; k < CLASS_COUNT; k++) begin
      agree = ~(img ^ class_weights(k));
      score = 0;
      for (int i = 0; i < IMG_BITS; i++) score += agree[i];
      if (score > best_score) begin  // Strict, lowest index keeps a tie
        best_score = score;
        best       = 4'(k);
      end
    end
    return best;
  endfunction

  // ==========================================================================
  // Drivers
  // ==========================================================================
  task automatic step(input int cycles);
    repeat (cycles) @(posedge clk);
    #5;
  endtask

  task automatic draw_bytes(input int count);
    for (int i = 0; i < count; i++) begin
      rng = xorshift32(rng);
      frame_data[i] = rng[7:0];
    end
  endtask

  task automatic apply_to_model(input int count);
    for (int i = 0; i < count; i++) model_img[8*i +: 8] = frame_data[i];  // LSB = pixel 8i
  endtask

  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin  // Mode 0, MSB first
      copi = b[i];
      sclk = 1'b0;
      step(4);
      sclk = 1'b1;
      step(4);
    end
  endtask

  task automatic spi_frame(input logic [7:0] opcode, input int nbytes, input logic full);
    spi_cs_n = 1'b0;
    step(4);
    spi_byte(opcode);
    in_load = full;                                  // Opcode taken by now
    for (int i = 0; i < nbytes; i++) begin
      if (full && i == nbytes - 1) in_load = 1'b0;   // Last byte ends the window
      spi_byte(frame_data[i]);
    end
    sclk = 1'b0;
    step(4);
    spi_cs_n = 1'b1;
  endtask

  task automatic expect_result(input logic [3:0] c);
    exp_class = c;
    exp_push  = 1'b1;
    step(1);
    exp_push  = 1'b0;
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while ((pending != 0 || !status_ready) && cnt < IDLE_LIMIT) begin
      step(1);
      cnt++;
    end
    if (cnt >= IDLE_LIMIT) begin
      stall_errs++;
      $display("frame ending at %0t never settled, controller busy or result missing", $time);
    end
    step(8);  // Chip select gap
  endtask

  task automatic close_test(input int kind);
    test_kind = kind;
    test_end  = 1'b1;
    step(1);
    test_end  = 1'b0;
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    sclk       = 1'b0;
    copi       = 1'b0;
    spi_cs_n   = 1'b1;
    in_load    = 1'b0;
    exp_push   = 1'b0;
    exp_class  = 4'd0;
    test_end   = 1'b0;
    test_kind  = 0;
    stall_errs = 0;
    rng        = 32'hae92d41e;
    model_img  = '0;
    repeat (16) @(posedge clk);
    #5 rst_n = 1'b1;
    step(4);
    close_test(0);
    for (int t = 0; t < N_LOADS; t++) begin
      draw_bytes(IMG_BYTES);
      apply_to_model(IMG_BYTES);
      expect_result(model_winner(model_img));
      spi_frame(OP_LOAD, IMG_BYTES, 1'b1);
      wait_idle();
      close_test(1);
    end
    spi_frame(OP_CLEAR, 0, 1'b0);
    wait_idle();
    model_img = '0;
    expect_result(model_winner(model_img));
    spi_frame(OP_RUN, 0, 1'b0);
    wait_idle();
    close_test(2);
    for (int t = 0; t < N_ABORTS; t++) begin
      rng = xorshift32(rng);
      n   = 1 + int'(rng % 15);                      // 1..15 bytes then abort
      draw_bytes(n);
      apply_to_model(n);
      spi_frame(OP_LOAD, n, 1'b0);
      wait_idle();
      expect_result(model_winner(model_img));
      spi_frame(OP_RUN, 0, 1'b0);
      wait_idle();
      close_test(3);
    end
    for (int t = 0; t < N_UNKNOWN; t++) begin
      op = OP_LOAD;
      while (op == OP_LOAD || op == OP_RUN || op == OP_CLEAR) begin
        rng = xorshift32(rng);
        op  = rng[7:0];
      end
      draw_bytes(3);                                 // Trailing bytes get skipped
      spi_frame(op, 3, 1'b0);
      wait_idle();
      close_test(4);
    end
    step(4);
    total_errs = err_count + stall_errs + DUT.u_ctrl.u_props.assert_fails;
    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, total_errs);
    if (total_errs == 0 && tests_fail == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Bounded by the longest frames plus slack
  initial begin
    #(WATCHDOG_NS);
    $display("run timed out at %0t, the DUT stopped making progress", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== src/controller_fsm.sv ====
`timescale 1ns/100ps

module controller_fsm import bnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cs_active,
  input  logic       spi_byte_valid,
  input  logic [7:0] spi_rx_data,
  input  logic       buffer_full,
  input  logic       result_ready,
  output logic       rx_enable,
  output logic       byte_taken,
  output logic       buffer_write_enable,
  output logic       clear_buffer,
  output logic       load_start,
  output logic       bnn_start,
  output logic       send_image,
  output logic       status_ready
);

  ctrl_state_t state, state_nx;
  opcode_t     op;

  assign op = opcode_t'(spi_rx_data);  // Unknown values fall to default

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= ST_IDLE;
    else        state <= state_nx;
  end

  // ==========================================================================
  // Next state and strobes
  // ==========================================================================
  always_comb begin
    state_nx            = state;
    rx_enable           = 1'b0;
    byte_taken          = 1'b0;
    buffer_write_enable = 1'b0;
    clear_buffer        = 1'b0;
    load_start          = 1'b0;
    bnn_start           = 1'b0;
    send_image          = 1'b0;
    status_ready        = 1'b0;
    case (state)
      ST_IDLE: begin
        status_ready = 1'b1;
        if (cs_active) state_nx = ST_CMD;  // New frame
      end
      ST_CMD: begin
        rx_enable = 1'b1;
        if (!cs_active) begin
          state_nx = ST_IDLE;
        end else if (spi_byte_valid) begin
          byte_taken = 1'b1;
          case (op)
            OP_LOAD: begin
              load_start = 1'b1;  // Counter back to 0
              send_image = 1'b1;
              state_nx   = ST_LOAD;
            end
            OP_CLEAR: begin
              clear_buffer = 1'b1;
              state_nx     = ST_SKIP;
            end
            OP_RUN: begin
              bnn_start = 1'b1;
              state_nx  = ST_RUN;
            end
            default: state_nx = ST_SKIP;  // Ignored opcode
          endcase
        end
      end
      ST_LOAD: begin
        rx_enable  = 1'b1;
        send_image = ~buffer_full;
        if (buffer_full) begin           // Last byte landed last cycle
          bnn_start = 1'b1;
          state_nx  = ST_WAIT;
        end else if (!cs_active) begin
          state_nx = ST_IDLE;            // Aborted load, partial image kept
        end else if (spi_byte_valid) begin
          byte_taken          = 1'b1;
          buffer_write_enable = 1'b1;
        end
      end
      ST_RUN, ST_WAIT: begin
        // Chip select ignored until the result is out
        if (result_ready) state_nx = cs_active ? ST_SKIP : ST_IDLE;
      end
      ST_SKIP: begin
        status_ready = 1'b1;
        if (!cs_active) state_nx = ST_IDLE;
      end
      default: state_nx = ST_IDLE;
    endcase
  end

endmodule

// ==== src/image_buffer.sv ====
`timescale 1ns/100ps

module image_buffer import bnn_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear_buffer,
  input  logic                buffer_write_enable,
  input  logic [3:0]          write_addr,
  input  logic [7:0]          data_in,
  output logic [IMG_BITS-1:0] img_flat
);

  logic [7:0] img_mem [IMG_BYTES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < IMG_BYTES; i++) img_mem[i] <= 8'h00;
    end else if (clear_buffer) begin
      for (int i = 0; i < IMG_BYTES; i++) img_mem[i] <= 8'h00;  // Single cycle wipe
    end else if (buffer_write_enable) begin
      img_mem[write_addr] <= data_in;
    end
  end

  // Byte i -> pixels 8i..8i+7, LSB first
  always_comb begin
    for (int i = 0; i < IMG_BYTES; i++) img_flat[8*i +: 8] = img_mem[i];
  end

endmodule

// ==== src/pixel_counter.sv ====
`timescale 1ns/100ps

module pixel_counter import bnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_start,
  input  logic       clear_buffer,
  input  logic       buffer_write_enable,
  output logic [3:0] write_addr,
  output logic       buffer_full
);

  // One extra bit so IMG_BYTES itself fits
  logic [$clog2(IMG_BYTES):0] byte_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_cnt <= '0;
    end else if (load_start || clear_buffer) begin
      byte_cnt <= '0;                     // New load or wiped buffer
    end else if (buffer_write_enable && !buffer_full) begin
      byte_cnt <= byte_cnt + 1'b1;        // Saturates at IMG_BYTES
    end
  end

  assign buffer_full = (byte_cnt == IMG_BYTES);
  assign write_addr  = byte_cnt[3:0];     // Next slot to fill

endmodule

// ==== src/result_display.sv ====
`timescale 1ns/100ps

module result_display import bnn_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               result_ready,
  input  logic [CLASS_W-1:0] result_out,
  output logic [6:0]         seg
);

  logic [CLASS_W-1:0] shown_digit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)            shown_digit <= '0;          // Shows 0 after reset
    else if (result_ready) shown_digit <= result_out;
  end

  // Active low, bit 6 = g ... bit 0 = a
  always_comb begin
    case (shown_digit)
      4'd0:    seg = 7'b1000000;
      4'd1:    seg = 7'b1111001;
      4'd2:    seg = 7'b0100100;
      4'd3:    seg = 7'b0110000;
      4'd4:    seg = 7'b0011001;
      4'd5:    seg = 7'b0010010;
      4'd6:    seg = 7'b0000010;
      4'd7:    seg = 7'b1111000;
      4'd8:    seg = 7'b0000000;
      4'd9:    seg = 7'b0010000;
      default: seg = 7'b1111111;  // Blank
    endcase
  end

endmodule

// ==== src/spi_peripheral.sv ====
`timescale 1ns/100ps

module spi_peripheral (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       copi,
  input  logic       spi_cs_n,
  input  logic       rx_enable,
  input  logic       byte_taken,
  output logic [7:0] spi_rx_data,
  output logic       spi_byte_valid,
  output logic       cs_active
);

  // ==========================================================================
  // Input synchronizers
  // ==========================================================================
  logic [1:0] sclk_sync, copi_sync, cs_sync;
  logic       sclk_d;       // Last synchronized SCLK
  logic       sclk_rise;
  logic [2:0] bit_cnt;      // Bit position in current byte
  logic [7:0] shift_reg;
  logic       byte_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= 2'b00;
      copi_sync <= 2'b00;
      cs_sync   <= 2'b11;   // Deselected out of reset
      sclk_d    <= 1'b0;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      copi_sync <= {copi_sync[0], copi};
      cs_sync   <= {cs_sync[0], spi_cs_n};
      sclk_d    <= sclk_sync[1];
    end
  end

  assign cs_active = ~cs_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_d;                 // Mode 0 sample edge
  assign byte_done = sclk_rise & cs_active & (bit_cnt == 3'd7);

  // Bit counter restarts with every chip select
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)                      bit_cnt <= 3'd0;
    else if (!cs_active)             bit_cnt <= 3'd0;
    else if (sclk_rise)              bit_cnt <= bit_cnt + 3'd1;  // Wraps after 8
  end

  // Shift MSB first, hand off full byte
  always_ff @(posedge clk) begin
    if (sclk_rise && cs_active) shift_reg <= {shift_reg[6:0], copi_sync[1]};
    if (byte_done && rx_enable) spi_rx_data <= {shift_reg[6:0], copi_sync[1]};
  end

  // Valid held until consumer takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)                      spi_byte_valid <= 1'b0;
    else if (!cs_active)             spi_byte_valid <= 1'b0;  // Frame over
    else if (byte_done && rx_enable) spi_byte_valid <= 1'b1;
    else if (byte_taken)             spi_byte_valid <= 1'b0;
  end

endmodule

// ==== src/system_controller.sv ====
`timescale 1ns/100ps

module system_controller import bnn_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       copi,
  input  logic       spi_cs_n,
  output logic [6:0] seg,
  output logic       result_ready,
  output logic       send_image,
  output logic       status_ready
);

  // ==========================================================================
  // Internal nets
  // ==========================================================================
  logic [7:0]          spi_rx_data;
  logic                spi_byte_valid, cs_active;
  logic                rx_enable, byte_taken;
  logic                buffer_write_enable, clear_buffer, load_start;
  logic                buffer_full;
  logic [3:0]          write_addr;
  logic [IMG_BITS-1:0] img_flat;
  logic                bnn_start;
  logic [CLASS_W-1:0]  result_out;

  spi_peripheral u_spi (
    .clk, .rst_n, .sclk, .copi, .spi_cs_n,
    .rx_enable, .byte_taken,
    .spi_rx_data, .spi_byte_valid, .cs_active
  );

  controller_fsm u_ctrl (
    .clk, .rst_n, .cs_active, .spi_byte_valid, .spi_rx_data,
    .buffer_full, .result_ready,
    .rx_enable, .byte_taken, .buffer_write_enable, .clear_buffer,
    .load_start, .bnn_start, .send_image, .status_ready
  );

  pixel_counter u_cnt (
    .clk, .rst_n, .load_start, .clear_buffer, .buffer_write_enable,
    .write_addr, .buffer_full
  );

  image_buffer u_img (
    .clk, .rst_n, .clear_buffer, .buffer_write_enable, .write_addr,
    .data_in (spi_rx_data),   // SPI byte straight into the array
    .img_flat
  );

  bnn_classifier u_bnn (
    .clk, .rst_n, .bnn_start,
    .img_in (img_flat),
    .result_out, .result_ready
  );

  result_display u_disp (
    .clk, .rst_n, .result_ready, .result_out, .seg
  );

endmodule
